/* src.f */
source/tsc_pkg.sv
source/inst_stream_if.sv
source/inst_fetch.sv
source/inst_queue.sv
source/control_unit.sv
source/alu.sv
source/register_file.sv
source/execute_stage.sv
source/tsc_core.sv
tb/tsc_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tsc_core_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tsc_core_tb.sv */
`timescale 1ns/1ns

module tsc_core_tb import tsc_pkg::*; ();

	localparam int clk_period = 100;
	localparam int reset_cycles = 5;
	localparam int prog_len = 52;
	localparam int settle_cycles = 20;
	localparam int timeout_ns = (prog_len * 10 + reset_cycles + settle_cycles) * clk_period;
	localparam int num_outputs = 16;
	localparam int expected_num_inst = 43; // every executed address from 0 to the HLT at 50

	// WWD values in program order, worked out by hand from the ISA rules
	localparam logic [15:0] expected_out [num_outputs] = '{
		16'h12b5, 16'h12b1, 16'h2566, 16'hfffc, 16'h12b4, 16'hfffd, 16'hed4a, 16'hed4b,
		16'h256a, 16'hfffe, 16'h12b1, 16'hfffc, 16'h12b5, 16'hfffe, 16'h0028, 16'h0030
	};

	logic clk;
	logic reset_n;
	logic imem_ack;
	logic [15:0] imem_data;
	logic imem_req;
	logic [15:0] imem_addr;
	logic [15:0] output_port;
	logic output_valid;
	logic halted;
	logic [15:0] num_inst;
	logic [15:0] program_mem [prog_len];
	integer seed = 32'h94c0;
	int errors = 0;
	int out_index = 0;

	tsc_core i_dut (
		.clk(clk),
		.reset_n(reset_n),
		.imem_ack(imem_ack),
		.imem_data(imem_data),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.output_port(output_port),
		.output_valid(output_valid),
		.halted(halted),
		.num_inst(num_inst)
	);

	function automatic logic [15:0] encode_rtype(logic [1:0] rs, logic [1:0] rt,
		logic [1:0] rd, func_t fn);
		return {op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] encode_imm(opcode_t op, logic [1:0] rs, logic [1:0] rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] encode_jump(opcode_t op, logic [11:0] target);
		return {op, target};
	endfunction

	function automatic logic [15:0] read_imem(logic [15:0] addr);
		if (addr < prog_len)
			return program_mem[addr[5:0]];
		return {op_lwd, addr[11:0] ^ {8'h00, addr[15:12]}}; // past the program every word is a no-op
	endfunction

	task automatic count_failure(string what);
		errors++;
		$display("FAIL %0t ns: %s", $time, what);
	endtask

	task automatic load_program();
		program_mem[0] = encode_imm(op_lhi, 2'd0, 2'd0, 8'h12); // r0 = 0x1200
		program_mem[1] = encode_imm(op_ori, 2'd0, 2'd0, 8'hb5); // zero extended, r0 = 0x12b5
		program_mem[2] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd);
		program_mem[3] = encode_imm(op_adi, 2'd0, 2'd1, 8'hfc); // r1 = r0 - 4
		program_mem[4] = encode_rtype(2'd1, 2'd0, 2'd0, fn_wwd);
		program_mem[5] = encode_rtype(2'd0, 2'd1, 2'd2, fn_add);
		program_mem[6] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[7] = encode_rtype(2'd1, 2'd0, 2'd3, fn_sub); // r3 = -4
		program_mem[8] = encode_rtype(2'd3, 2'd0, 2'd0, fn_wwd);
		program_mem[9] = encode_rtype(2'd0, 2'd3, 2'd2, fn_and);
		program_mem[10] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[11] = encode_rtype(2'd1, 2'd3, 2'd2, fn_orr);
		program_mem[12] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[13] = encode_rtype(2'd0, 2'd0, 2'd2, fn_not);
		program_mem[14] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[15] = encode_rtype(2'd0, 2'd0, 2'd2, fn_tcp);
		program_mem[16] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[17] = encode_rtype(2'd0, 2'd0, 2'd2, fn_shl);
		program_mem[18] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[19] = encode_rtype(2'd3, 2'd0, 2'd2, fn_shr); // negative input keeps its sign
		program_mem[20] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		// each branch skips one WWD when taken
		program_mem[21] = encode_imm(op_bne, 2'd0, 2'd1, 8'h01);
		program_mem[22] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd);
		program_mem[23] = encode_imm(op_bne, 2'd0, 2'd0, 8'h01);
		program_mem[24] = encode_rtype(2'd1, 2'd0, 2'd0, fn_wwd);
		program_mem[25] = encode_imm(op_beq, 2'd0, 2'd0, 8'h01);
		program_mem[26] = encode_rtype(2'd3, 2'd0, 2'd0, fn_wwd);
		program_mem[27] = encode_imm(op_beq, 2'd0, 2'd1, 8'h01);
		program_mem[28] = encode_rtype(2'd3, 2'd0, 2'd0, fn_wwd);
		program_mem[29] = encode_imm(op_bgz, 2'd0, 2'd0, 8'h01);
		program_mem[30] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[31] = encode_imm(op_bgz, 2'd3, 2'd0, 8'h01);
		program_mem[32] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd);
		program_mem[33] = encode_imm(op_blz, 2'd3, 2'd0, 8'h01);
		program_mem[34] = encode_rtype(2'd1, 2'd0, 2'd0, fn_wwd);
		program_mem[35] = encode_imm(op_blz, 2'd0, 2'd0, 8'h01);
		program_mem[36] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[37] = encode_jump(op_jmp, 12'd39);
		program_mem[38] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd);
		program_mem[39] = encode_jump(op_jal, 12'd41); // r2 = 40
		program_mem[40] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd);
		program_mem[41] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[42] = encode_imm(op_lhi, 2'd0, 2'd3, 8'h00);
		program_mem[43] = encode_imm(op_ori, 2'd3, 2'd3, 8'd46);
		program_mem[44] = encode_rtype(2'd3, 2'd0, 2'd0, fn_jpr);
		program_mem[45] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd);
		program_mem[46] = encode_imm(op_adi, 2'd3, 2'd3, 8'd3); // r3 = 49
		program_mem[47] = encode_rtype(2'd3, 2'd0, 2'd0, fn_jrl); // r2 = 48
		program_mem[48] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd);
		program_mem[49] = encode_rtype(2'd2, 2'd0, 2'd0, fn_wwd);
		program_mem[50] = encode_rtype(2'd0, 2'd0, 2'd0, fn_hlt);
		program_mem[51] = encode_rtype(2'd0, 2'd0, 2'd0, fn_wwd); // fetched but never executed
	endtask

	task automatic check_idle_outputs(input logic in_reset);
		if (in_reset)
			assert (imem_req === 1'b0) else count_failure("imem_req high during reset");
		assert (output_valid === 1'b0) else count_failure("output_valid high around reset");
		assert (halted === 1'b0) else count_failure("halted high around reset");
		assert (num_inst === 16'h0000) else count_failure("num_inst not zero around reset");
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// four-phase memory with a random wait before raising and before dropping ack
	initial begin : imem_responder
		int unsigned wait_cycles;
		imem_ack = 1'b0;
		imem_data = '0;
		forever begin
			@(negedge clk);
			if (reset_n && imem_req) begin
				wait_cycles = $unsigned($random(seed)) % 4;
				repeat (wait_cycles) @(negedge clk);
				imem_data = read_imem(imem_addr);
				imem_ack = 1'b1;
				do @(negedge clk); while (imem_req);
				wait_cycles = $unsigned($random(seed)) % 4;
				repeat (wait_cycles) @(negedge clk);
				imem_ack = 1'b0;
			end
		end
	end

	// every output pulse is matched against the next entry of the expectation table
	always @(negedge clk) begin
		if (reset_n && output_valid) begin
			assert (out_index < num_outputs)
				else count_failure($sformatf("unexpected WWD output %h", output_port));
			if (out_index < num_outputs)
				assert (output_port === expected_out[out_index])
					else count_failure($sformatf("WWD %0d is %h, expected %h", out_index,
						output_port, expected_out[out_index]));
			out_index++;
		end
	end

	initial begin : main_sequence
		reset_n = 1'b0;
		load_program();
		repeat (reset_cycles) begin
			@(negedge clk);
			check_idle_outputs(1'b1);
		end
		reset_n = 1'b1;
		@(negedge clk);
		check_idle_outputs(1'b0);
		wait (halted === 1'b1);
		repeat (settle_cycles) begin
			@(negedge clk);
			assert (halted === 1'b1) else count_failure("halted dropped after HLT");
			assert (output_valid === 1'b0) else count_failure("output_valid pulse after HLT");
		end
		assert (num_inst === 16'(expected_num_inst))
			else count_failure($sformatf("num_inst is %0d, expected %0d", num_inst,
				expected_num_inst));
		assert (out_index == num_outputs)
			else count_failure($sformatf("saw %0d WWD values, expected %0d", out_index,
				num_outputs));
		$display("%0d of %0d WWD values seen, %0d errors", out_index, num_outputs, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("timeout: the core did not halt within %0d ns", timeout_ns);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* source/tsc_core.sv */
`timescale 1ns/1ns

module tsc_core import tsc_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic imem_ack,
	input logic [word_width-1:0] imem_data,
	output logic imem_req,
	output logic [word_width-1:0] imem_addr,
	output logic [word_width-1:0] output_port,
	output logic output_valid,
	output logic halted,
	output logic [word_width-1:0] num_inst
);

	logic redirect;
	logic [word_width-1:0] redirect_pc;

	inst_stream_if fetch_bus ();
	inst_stream_if issue_bus ();

	inst_fetch i_inst_fetch (
		.clk(clk),
		.reset_n(reset_n),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_ack(imem_ack),
		.imem_data(imem_data),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.out(fetch_bus)
	);

	inst_queue i_inst_queue (
		.clk(clk),
		.reset_n(reset_n),
		.flush(redirect), // wrong-path words are dropped when execute changes course
		.in(fetch_bus),
		.out(issue_bus)
	);

	execute_stage i_execute_stage (
		.clk(clk),
		.reset_n(reset_n),
		.in(issue_bus),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.output_port(output_port),
		.output_valid(output_valid),
		.halted(halted),
		.num_inst(num_inst)
	);

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import tsc_pkg::*; (
	input logic clk,
	input logic reset_n,
	inst_stream_if.sink in,
	output logic redirect,
	output logic [word_width-1:0] redirect_pc,
	output logic [word_width-1:0] output_port,
	output logic output_valid,
	output logic halted,
	output logic [word_width-1:0] num_inst
);

	ctrl_t ctrl;
	logic fire;
	logic [1:0] rs;
	logic [1:0] rt;
	logic [1:0] rd;
	logic [imm_width-1:0] imm;
	logic [word_width-1:0] imm_ext;
	logic [word_width-1:0] pc_plus1;
	logic [word_width-1:0] rs_data;
	logic [word_width-1:0] rt_data;
	logic [word_width-1:0] alu_b;
	logic [word_width-1:0] alu_result;
	logic [word_width-1:0] write_data;
	logic [1:0] write_addr;
	logic cond_true;

	assign in.ready = !halted;
	assign fire = in.valid && in.ready; // each accepted instruction retires in this cycle

	assign rs = in.instr[11:10];
	assign rt = in.instr[9:8];
	assign rd = in.instr[7:6];
	assign imm = in.instr[imm_width-1:0];
	assign pc_plus1 = in.pc + 1'b1;
	assign imm_ext = ctrl.imm_zero_ext ? {{(word_width-imm_width){1'b0}}, imm}
		: {{(word_width-imm_width){imm[imm_width-1]}}, imm};
	assign alu_b = ctrl.use_imm ? imm_ext : rt_data;

	control_unit i_control_unit (
		.opcode(opcode_t'(in.instr[15:12])),
		.func(func_t'(in.instr[5:0])),
		.ctrl(ctrl)
	);

	alu i_alu (
		.op(ctrl.alu_op),
		.a(rs_data),
		.b(alu_b),
		.result(alu_result)
	);

	always_comb begin
		if (ctrl.link)
			write_data = pc_plus1;
		else if (ctrl.load_high)
			write_data = {imm, {(word_width-imm_width){1'b0}}};
		else
			write_data = alu_result;
	end

	assign write_addr = ctrl.link ? link_reg : (ctrl.dest_rt ? rt : rd);

	register_file i_register_file (
		.clk(clk),
		.reset_n(reset_n),
		.rs_addr(rs),
		.rt_addr(rt),
		.write_en(fire && ctrl.reg_write),
		.write_addr(write_addr),
		.write_data(write_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	always_comb begin
		case (ctrl.branch_cond)
			cond_ne: cond_true = (rs_data != rt_data);
			cond_eq: cond_true = (rs_data == rt_data);
			cond_gz: cond_true = ($signed(rs_data) > 0);
			default: cond_true = ($signed(rs_data) < 0);
		endcase
	end

	assign redirect = fire && ((ctrl.branch && cond_true) || ctrl.jump_target || ctrl.jump_reg);

	always_comb begin
		if (ctrl.jump_reg)
			redirect_pc = rs_data;
		else if (ctrl.jump_target)
			redirect_pc = {in.pc[word_width-1:12], in.instr[11:0]}; // stays in the current 4K page
		else
			redirect_pc = pc_plus1 + imm_ext;
	end

	assign output_port = rs_data;
	assign output_valid = fire && ctrl.wwd;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			halted <= 1'b0;
			num_inst <= '0;
		end else if (fire) begin
			num_inst <= num_inst + 1'b1; // HLT counts as retired too
			if (ctrl.halt)
				halted <= 1'b1;
		end
	end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ns

module register_file import tsc_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic [1:0] rs_addr,
	input logic [1:0] rt_addr,
	input logic write_en,
	input logic [1:0] write_addr,
	input logic [word_width-1:0] write_data,
	output logic [word_width-1:0] rs_data,
	output logic [word_width-1:0] rt_data
);

	logic [word_width-1:0] regs [4];

	// reads see the old value until the edge that writes
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	always_ff @(posedge clk) begin
		if (!reset_n)
			regs <= '{default: '0};
		else if (write_en)
			regs[write_addr] <= write_data;
	end

endmodule

/* source/alu.sv */
`timescale 1ns/1ns

module alu import tsc_pkg::*; (
	input alu_op_t op,
	input logic [word_width-1:0] a,
	input logic [word_width-1:0] b,
	output logic [word_width-1:0] result
);

	always_comb begin
		case (op)
			alu_add: result = a + b; // wraps modulo 2^16
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_not: result = ~a;
			alu_tcp: result = ~a + 1'b1;
			alu_shl: result = {a[word_width-2:0], 1'b0};
			alu_shr: result = {a[word_width-1], a[word_width-1:1]}; // sign bit is kept
			default: result = '0;
		endcase
	end

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ns

module control_unit import tsc_pkg::*; (
	input opcode_t opcode,
	input func_t func,
	output ctrl_t ctrl
);

	always_comb begin
		ctrl = '0; // anything not listed below is a no-operation, LWD and SWD included
		case (opcode)
			op_bne: begin
				ctrl.branch = 1'b1;
				ctrl.branch_cond = cond_ne;
			end
			op_beq: begin
				ctrl.branch = 1'b1;
				ctrl.branch_cond = cond_eq;
			end
			op_bgz: begin
				ctrl.branch = 1'b1;
				ctrl.branch_cond = cond_gz;
			end
			op_blz: begin
				ctrl.branch = 1'b1;
				ctrl.branch_cond = cond_lz;
			end
			op_adi, op_ori: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_rt = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.imm_zero_ext = (opcode == op_ori);
				ctrl.alu_op = (opcode == op_ori) ? alu_or : alu_add;
			end
			op_lhi: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_rt = 1'b1;
				ctrl.load_high = 1'b1;
			end
			op_jmp: ctrl.jump_target = 1'b1;
			op_jal: begin
				ctrl.jump_target = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.link = 1'b1;
			end
			op_rtype: begin
				case (func)
					fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_op_t'(func[2:0]); // function codes 0..7 follow the ALU order
					end
					fn_jpr: ctrl.jump_reg = 1'b1;
					fn_jrl: begin
						ctrl.jump_reg = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.link = 1'b1;
					end
					fn_wwd: ctrl.wwd = 1'b1;
					fn_hlt: ctrl.halt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// execute picks one target source, so at most one flow control kind per instruction
	always_comb begin
		assert ($onehot0({ctrl.jump_target, ctrl.jump_reg, ctrl.branch}))
			else $error("conflicting flow control decode");
	end

endmodule

/* source/inst_queue.sv */
`timescale 1ns/1ns

module inst_queue import tsc_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic flush,
	inst_stream_if.sink in,
	inst_stream_if.source out
);

	logic [word_width-1:0] instr_mem [queue_depth];
	logic [word_width-1:0] pc_mem [queue_depth];
	logic [queue_ptr_width-1:0] wr_ptr;
	logic [queue_ptr_width-1:0] rd_ptr;
	logic [queue_count_width-1:0] count;
	logic push;
	logic pop;

	assign in.ready = (count != queue_count_width'(queue_depth));
	assign out.valid = (count != '0);
	assign out.instr = instr_mem[rd_ptr];
	assign out.pc = pc_mem[rd_ptr];

	assign push = in.valid && in.ready && !flush; // an offered word is lost on flush
	assign pop = out.valid && out.ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == queue_ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == queue_ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			instr_mem[wr_ptr] <= in.instr;
			pc_mem[wr_ptr] <= in.pc;
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n) count <= queue_depth)
		else $error("instruction queue count overflow");

	// a stray pop leaves the read pointer ahead of the write pointer once the queue drains
	assert property (@(posedge clk) disable iff (!reset_n) count == '0 |-> rd_ptr == wr_ptr)
		else $error("pop from an empty instruction queue");

endmodule

/* source/inst_fetch.sv */
`timescale 1ns/1ns

module inst_fetch import tsc_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic redirect,
	input logic [word_width-1:0] redirect_pc,
	input logic imem_ack,
	input logic [word_width-1:0] imem_data,
	output logic imem_req,
	output logic [word_width-1:0] imem_addr,
	inst_stream_if.source out
);

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_req,
		fetch_release
	} fetch_state_t;

	fetch_state_t state;
	logic [word_width-1:0] fetch_pc;
	logic hold_valid;
	logic [word_width-1:0] hold_instr;
	logic [word_width-1:0] hold_pc;
	logic discard; // a redirect hit the open request, so its data is thrown away

	assign imem_req = (state == fetch_req);
	assign out.valid = hold_valid;
	assign out.instr = hold_instr;
	assign out.pc = hold_pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= fetch_idle;
			fetch_pc <= '0;
			imem_addr <= '0;
			hold_valid <= 1'b0;
			discard <= 1'b0;
		end else begin
			if (out.valid && out.ready)
				hold_valid <= 1'b0;
			case (state)
				fetch_idle: begin
					if (!hold_valid && !imem_ack && !redirect) begin // only with a free slot
						state <= fetch_req;
						imem_addr <= fetch_pc;
						discard <= 1'b0;
					end
				end
				fetch_req: begin
					if (imem_ack) begin
						state <= fetch_release;
						if (!discard && !redirect) begin
							hold_valid <= 1'b1;
							fetch_pc <= imem_addr + 1'b1;
						end
					end else if (redirect) begin
						discard <= 1'b1;
					end
				end
				default: begin
					if (!imem_ack)
						state <= fetch_idle; // memory has finished the four-phase cycle
				end
			endcase
			// a redirect wins over everything above and kills the held word
			if (redirect) begin
				fetch_pc <= redirect_pc;
				hold_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == fetch_req && imem_ack) begin
			hold_instr <= imem_data;
			hold_pc <= imem_addr;
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		imem_req && !imem_ack |=> imem_req && $stable(imem_addr))
		else $error("imem request dropped or address moved before ack");

endmodule

/* source/inst_stream_if.sv */
`timescale 1ns/1ns

interface inst_stream_if import tsc_pkg::*; ();

	logic valid;
	logic ready;
	logic [word_width-1:0] instr;
	logic [word_width-1:0] pc; // address the word was fetched from

	// a word moves on an edge where valid and ready are both high
	modport source (
		output valid,
		output instr,
		output pc,
		input ready
	);

	modport sink (
		input valid,
		input instr,
		input pc,
		output ready
	);

endinterface

/* source/tsc_pkg.sv */
package tsc_pkg;

	localparam int word_width = 16;
	localparam int imm_width = 8;
	localparam int queue_depth = 4;
	localparam int queue_ptr_width = $clog2(queue_depth);
	localparam int queue_count_width = $clog2(queue_depth + 1);
	localparam logic [1:0] link_reg = 2'd2; // JAL and JRL leave the return address here

	typedef enum logic [3:0] {
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_bgz = 4'd2,
		op_blz = 4'd3,
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_jal = 4'd10,
		op_rtype = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr
	} alu_op_t;

	typedef enum logic [1:0] {
		cond_ne,
		cond_eq,
		cond_gz,
		cond_lz
	} branch_cond_t;

	typedef struct packed {
		logic reg_write;
		logic dest_rt; // destination is rt instead of rd
		logic use_imm;
		logic imm_zero_ext;
		logic load_high;
		alu_op_t alu_op;
		logic branch;
		branch_cond_t branch_cond;
		logic jump_target; // JMP and JAL
		logic jump_reg; // JPR and JRL
		logic link;
		logic wwd;
		logic halt;
	} ctrl_t;

endpackage
